//--- include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Width of a data word and of the program counter
`define MIPS_DATA_W 32

// Architectural integer registers, register 0 included
`define MIPS_REG_N 32

// PC carried by the first instruction after reset
`define MIPS_RESET_PC 32'hbfc0_0000

// Byte distance between consecutive instructions
`define MIPS_PC_STEP 4

`endif

//--- source/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_W-1:0] word_t;
    typedef logic [$clog2(`MIPS_REG_N)-1:0] creg_addr_t;
    typedef logic [4:0] shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // imm is already sign or zero extended by decode
    typedef struct packed {
        logic       valid;
        word_t      pc;
        alu_op_t    alu_op;
        creg_addr_t rs;
        creg_addr_t rt;
        creg_addr_t dst;
        logic       use_imm;
        word_t      imm;
        shamt_t     shamt;
        logic       wen;
    } decode_data_t;

    // Operands a and b hold final values, bypass and immediate select done
    typedef struct packed {
        logic       valid;
        word_t      pc;
        alu_op_t    alu_op;
        creg_addr_t dst;
        logic       wen;
        word_t      a;
        word_t      b;
    } issue_data_t;

    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      data;
    } rf_w_t;

    typedef struct packed {
        logic       valid;
        creg_addr_t addr;
        word_t      data;
    } bypass_upd_t;

endpackage

//--- source/decode.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module decode import mips_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         inst_valid,
    input  word_t        inst,
    output decode_data_t decode_data
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    logic       inst_valid_q;
    word_t      inst_q;
    word_t      pc_q;
    word_t      pc_cnt;
    logic       supported;
    logic       sign_ext;
    logic       is_itype;
    alu_op_t    alu_op;
    creg_addr_t dst;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_valid_q <= 1'b0;
            pc_cnt       <= `MIPS_RESET_PC;
        end else begin
            inst_valid_q <= inst_valid;
            if (inst_valid) begin
                pc_cnt <= pc_cnt + `MIPS_PC_STEP;
            end
        end
    end

    // The counter value is the PC of the word being accepted
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            inst_q <= inst;
            pc_q   <= pc_cnt;
        end
    end

    always_comb begin
        supported = 1'b1;
        sign_ext  = 1'b0;
        is_itype  = 1'b1;
        alu_op    = ALU_ADD;
        case (inst_q[31:26])
            OP_SPECIAL: begin
                is_itype = 1'b0;
                case (inst_q[5:0])
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: supported = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op   = ALU_ADD;
                sign_ext = 1'b1;
            end
            OP_SLTI: begin
                alu_op   = ALU_SLT;
                sign_ext = 1'b1;
            end
            OP_SLTIU: begin
                // Sign extended first, then compared unsigned
                alu_op   = ALU_SLTU;
                sign_ext = 1'b1;
            end
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            OP_LUI:  alu_op = ALU_LUI;
            default: supported = 1'b0;
        endcase

        dst = is_itype ? inst_q[20:16] : inst_q[15:11];

        decode_data.valid   = inst_valid_q;
        decode_data.pc      = pc_q;
        decode_data.alu_op  = alu_op;
        decode_data.rs      = inst_q[25:21];
        decode_data.rt      = inst_q[20:16];
        decode_data.dst     = dst;
        decode_data.use_imm = is_itype;
        decode_data.imm     = sign_ext ? {{16{inst_q[15]}}, inst_q[15:0]}
                                       : {16'b0, inst_q[15:0]};
        decode_data.shamt   = inst_q[10:6];
        decode_data.wen     = supported && (dst != '0);
    end

endmodule

//--- source/issue.sv
`timescale 1ns/1ps

module issue import mips_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  decode_data_t decode_data,
    input  word_t        rs_data,
    input  word_t        rt_data,
    output issue_data_t  issue_data
);

    issue_data_t issue_next;
    issue_data_t stage_q;
    logic        valid_q;
    logic        is_shift;

    always_comb begin
        is_shift = decode_data.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA};

        issue_next.valid  = decode_data.valid;
        issue_next.pc     = decode_data.pc;
        issue_next.alu_op = decode_data.alu_op;
        issue_next.dst    = decode_data.dst;
        issue_next.wen    = decode_data.wen;

        // Shifts move rt to operand a and take the amount from the word
        if (is_shift) begin
            issue_next.a = rt_data;
            issue_next.b = word_t'(decode_data.shamt);
        end else if (decode_data.use_imm) begin
            issue_next.a = rs_data;
            issue_next.b = decode_data.imm;
        end else begin
            issue_next.a = rs_data;
            issue_next.b = rt_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_next.valid) begin
            stage_q <= issue_next;
        end
    end

    always_comb begin
        issue_data       = stage_q;
        issue_data.valid = valid_q;
    end

endmodule

//--- source/bypass.sv
`timescale 1ns/1ps

module bypass import mips_pkg::*; (
    input  creg_addr_t  rs,
    input  creg_addr_t  rt,
    input  bypass_upd_t exec_bypass,
    input  bypass_upd_t retire_bypass,
    input  word_t       rs_rd,
    input  word_t       rt_rd,
    output word_t       rs_data,
    output word_t       rt_data
);

    // The instruction in execute is younger than the one retiring, so it wins
    function automatic word_t forward(
        input creg_addr_t  addr,
        input bypass_upd_t exec_src,
        input bypass_upd_t retire_src,
        input word_t       rf_value
    );
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (exec_src.valid && exec_src.addr == addr) begin
            value = exec_src.data;
        end else if (retire_src.valid && retire_src.addr == addr) begin
            value = retire_src.data;
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    assign rs_data = forward(rs, exec_bypass, retire_bypass, rs_rd);
    assign rt_data = forward(rt, exec_bypass, retire_bypass, rt_rd);

endmodule

//--- source/regfile.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module regfile import mips_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  rf_w_t      rfw,
    input  creg_addr_t ra0,
    input  creg_addr_t ra1,
    output word_t      rd0,
    output word_t      rd1
);

    // Register 0 has no storage
    word_t regs [1:`MIPS_REG_N-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `MIPS_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (rfw.wen && rfw.addr != '0) begin
            regs[rfw.addr] <= rfw.data;
        end
    end

    // No write-through here, bypass covers the retiring instruction
    assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

endmodule

//--- source/execute.sv
`timescale 1ns/1ps

module execute import mips_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  issue_data_t issue_data,
    output bypass_upd_t exec_bypass,
    output rf_w_t       rfw,
    output word_t       rt_pc
);

    word_t      op_a;
    word_t      op_b;
    word_t      alu_result;
    logic       wen_q;
    creg_addr_t addr_q;
    word_t      data_q;
    word_t      pc_q;

    always_comb begin
        op_a = issue_data.a;
        op_b = issue_data.b;
        case (issue_data.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_NOR:  alu_result = ~(op_a | op_b);
            ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(op_a < op_b);
            // Operand a is the shifted value, b the amount
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_LUI:  alu_result = {op_b[15:0], 16'b0};
            default:  alu_result = '0;
        endcase
    end

    assign exec_bypass = '{
        valid: issue_data.valid && issue_data.wen,
        addr:  issue_data.dst,
        data:  alu_result
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wen_q <= 1'b0;
        end else begin
            wen_q <= issue_data.valid && issue_data.wen;
        end
    end

    // Retire payload, kept for unsupported words as well so the PC is visible
    always_ff @(posedge clk) begin
        if (issue_data.valid) begin
            addr_q <= issue_data.dst;
            data_q <= alu_result;
            pc_q   <= issue_data.pc;
        end
    end

    assign rfw   = '{wen: wen_q, addr: addr_q, data: data_q};
    assign rt_pc = pc_q;

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps

module datapath import mips_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  inst_valid,
    input  word_t inst,
    output rf_w_t rfw_out,
    output word_t rt_pc_out
);

    decode_data_t decode_data;
    issue_data_t  issue_data;
    bypass_upd_t  exec_bypass;
    bypass_upd_t  retire_bypass;
    rf_w_t        rfw;
    word_t        rt_pc;
    word_t        rs_rd;
    word_t        rt_rd;
    word_t        rs_data;
    word_t        rt_data;

    decode decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .decode_data (decode_data)
    );

    regfile regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .rfw    (rfw),
        .ra0    (decode_data.rs),
        .ra1    (decode_data.rt),
        .rd0    (rs_rd),
        .rd1    (rt_rd)
    );

    bypass bypass (
        .rs            (decode_data.rs),
        .rt            (decode_data.rt),
        .exec_bypass   (exec_bypass),
        .retire_bypass (retire_bypass),
        .rs_rd         (rs_rd),
        .rt_rd         (rt_rd),
        .rs_data       (rs_data),
        .rt_data       (rt_data)
    );

    issue issue (
        .clk         (clk),
        .arst_n      (arst_n),
        .decode_data (decode_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .issue_data  (issue_data)
    );

    execute execute (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_data  (issue_data),
        .exec_bypass (exec_bypass),
        .rfw         (rfw),
        .rt_pc       (rt_pc)
    );

    // The retiring write doubles as the oldest forwarding source
    assign retire_bypass = '{valid: rfw.wen, addr: rfw.addr, data: rfw.data};

    assign rfw_out   = rfw;
    assign rt_pc_out = rt_pc;

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- verification/tb_datapath.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_datapath import mips_pkg::*; ();

    localparam int RANDOM_N       = 300;
    localparam int DIRECTED_N     = 60;
    localparam int TIMEOUT_CYCLES = 4 * (RANDOM_N + DIRECTED_N) + 100;

    localparam int F_SLL   = 'h00;
    localparam int F_SRL   = 'h02;
    localparam int F_SRA   = 'h03;
    localparam int F_ADDU  = 'h21;
    localparam int F_SUBU  = 'h23;
    localparam int F_AND   = 'h24;
    localparam int F_OR    = 'h25;
    localparam int F_XOR   = 'h26;
    localparam int F_NOR   = 'h27;
    localparam int F_SLT   = 'h2a;
    localparam int F_SLTU  = 'h2b;
    localparam int O_ADDIU = 'h09;
    localparam int O_SLTI  = 'h0a;
    localparam int O_SLTIU = 'h0b;
    localparam int O_ANDI  = 'h0c;
    localparam int O_ORI   = 'h0d;
    localparam int O_XORI  = 'h0e;
    localparam int O_LUI   = 'h0f;

    // Each accepted strobe leaves one entry that falls due on the cycle of its write
    typedef struct {
        word_t word;
        word_t pc;
        int    due;
    } pending_t;

    logic  clk;
    logic  arst_n;
    logic  inst_valid;
    word_t inst;
    rf_w_t rfw_out;
    word_t rt_pc_out;

    pending_t pending[$];
    word_t    shadow [0:`MIPS_REG_N-1];
    word_t    exp_pc;
    int       cycle = 0;
    int       checks = 0;
    int       errors = 0;
    int       test_checks = 0;
    int       test_errors = 0;
    int       r_functs [0:10] = '{'h00, 'h02, 'h03, 'h21, 'h23, 'h24, 'h25, 'h26, 'h27,
                                  'h2a, 'h2b};

    tb_clock #(.PERIOD_NS(40)) clock_gen (.clk(clk));

    datapath UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rfw_out    (rfw_out),
        .rt_pc_out  (rt_pc_out)
    );

    function automatic word_t rtype_word(input int funct, input int rd, input int rs,
                                         input int rt, input int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), 6'(funct)};
    endfunction

    function automatic word_t itype_word(input int op, input int rt, input int rs,
                                         input int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // ISA model of one instruction given its two source values
    function automatic rf_w_t expected_write(input word_t word, input word_t rs_val,
                                             input word_t rt_val);
        rf_w_t      result;
        logic       known;
        word_t      simm;
        word_t      zimm;
        logic [4:0] sh;
        simm        = {{16{word[15]}}, word[15:0]};
        zimm        = {16'b0, word[15:0]};
        sh          = word[10:6];
        known       = 1'b1;
        result.data = '0;
        result.addr = word[20:16];
        if (word[31:26] == 6'h00) begin
            result.addr = word[15:11];
            case (word[5:0])
                6'h00:   result.data = rt_val << sh;
                6'h02:   result.data = rt_val >> sh;
                6'h03:   result.data = $signed(rt_val) >>> sh;
                6'h21:   result.data = rs_val + rt_val;
                6'h23:   result.data = rs_val - rt_val;
                6'h24:   result.data = rs_val & rt_val;
                6'h25:   result.data = rs_val | rt_val;
                6'h26:   result.data = rs_val ^ rt_val;
                6'h27:   result.data = ~(rs_val | rt_val);
                6'h2a:   result.data = {31'b0, $signed(rs_val) < $signed(rt_val)};
                6'h2b:   result.data = {31'b0, rs_val < rt_val};
                default: known = 1'b0;
            endcase
        end else begin
            case (word[31:26])
                6'h09:   result.data = rs_val + simm;
                6'h0a:   result.data = {31'b0, $signed(rs_val) < $signed(simm)};
                6'h0b:   result.data = {31'b0, rs_val < simm};
                6'h0c:   result.data = rs_val & zimm;
                6'h0d:   result.data = rs_val | zimm;
                6'h0e:   result.data = rs_val ^ zimm;
                6'h0f:   result.data = {word[15:0], 16'b0};
                default: known = 1'b0;
            endcase
        end
        result.wen = known && (result.addr != '0);
        return result;
    endfunction

    // Most words are supported ops on registers 0 to 7 and the rest are raw random bits
    function automatic word_t random_word();
        int kind;
        kind = $urandom_range(0, 9);
        if (kind < 4) begin
            return rtype_word(r_functs[$urandom_range(0, 10)], $urandom_range(0, 7),
                              $urandom_range(0, 7), $urandom_range(0, 7),
                              $urandom_range(0, 31));
        end else if (kind < 8) begin
            return itype_word($urandom_range(9, 15), $urandom_range(0, 7),
                              $urandom_range(0, 7), $urandom_range(0, 'hffff));
        end
        return $urandom;
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        errors++;
    endtask

    task automatic send_inst(input word_t word, input int gap);
        pending_t entry;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
        entry.word = word;
        entry.pc   = exp_pc;
        entry.due  = cycle + 3;
        pending.push_back(entry);
        exp_pc = exp_pc + `MIPS_PC_STEP;
        repeat (gap) begin
            @(negedge clk);
            inst_valid = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        inst_valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        $display("Test %-10s done: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // Outputs are sampled just after the rising edge once they have settled
    initial begin
        pending_t cur;
        rf_w_t    exp_w;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            if (pending.size() != 0 && pending[0].due == cycle) begin
                cur   = pending.pop_front();
                exp_w = expected_write(cur.word, shadow[cur.word[25:21]],
                                       shadow[cur.word[20:16]]);
                checks++;
                assert (rfw_out.wen == exp_w.wen)
                else log_mismatch("rfw_out.wen", 32'(rfw_out.wen), 32'(exp_w.wen));
                if (exp_w.wen) begin
                    assert (rfw_out.addr == exp_w.addr)
                    else log_mismatch("rfw_out.addr", 32'(rfw_out.addr), 32'(exp_w.addr));
                    assert (rfw_out.data == exp_w.data)
                    else log_mismatch("rfw_out.data", rfw_out.data, exp_w.data);
                    assert (rt_pc_out == cur.pc)
                    else log_mismatch("rt_pc_out", rt_pc_out, cur.pc);
                    shadow[exp_w.addr] = exp_w.data;
                end
            end else begin
                assert (!rfw_out.wen)
                else begin
                    $display("Fail at %0t ns: write strobe with no instruction due", $time);
                    errors++;
                end
            end
        end
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(16234));
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        exp_pc     = `MIPS_RESET_PC;
        for (int i = 0; i < `MIPS_REG_N; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        // The write strobe must stay low through the idle cycles after reset
        repeat (4) @(negedge clk);
        send_inst(itype_word(O_ORI, 1, 0, 'h1234), 1);
        send_inst(itype_word(O_ORI, 2, 0, 'h5678), 0);
        send_inst(itype_word(O_ADDIU, 3, 0, -16), 2);
        finish_test("reset_pc");

        send_inst(itype_word(O_LUI, 1, 0, 'h8000), 3);
        send_inst(itype_word(O_ORI, 1, 1, 'h0005), 3);
        send_inst(itype_word(O_ORI, 2, 0, 'h0007), 3);
        send_inst(itype_word(O_ADDIU, 3, 0, -16), 3);
        send_inst(itype_word(O_LUI, 4, 0, 'h1234), 3);
        send_inst(itype_word(O_ORI, 4, 4, 'h5678), 3);
        send_inst(rtype_word(F_ADDU, 10, 1, 2, 0), 3);
        send_inst(rtype_word(F_SUBU, 11, 2, 3, 0), 3);
        send_inst(rtype_word(F_AND, 12, 1, 4, 0), 3);
        send_inst(rtype_word(F_OR, 13, 3, 4, 0), 3);
        send_inst(rtype_word(F_XOR, 14, 1, 4, 0), 3);
        send_inst(rtype_word(F_NOR, 15, 2, 4, 0), 3);
        send_inst(rtype_word(F_SLT, 16, 1, 2, 0), 3);
        send_inst(rtype_word(F_SLTU, 17, 1, 2, 0), 3);
        send_inst(rtype_word(F_SLL, 18, 0, 4, 4), 3);
        send_inst(rtype_word(F_SRL, 19, 0, 1, 3), 3);
        send_inst(rtype_word(F_SRA, 20, 0, 1, 3), 3);
        send_inst(itype_word(O_ADDIU, 21, 2, -100), 3);
        send_inst(itype_word(O_ANDI, 22, 4, 'hff0f), 3);
        send_inst(itype_word(O_ORI, 23, 3, 'h8001), 3);
        send_inst(itype_word(O_XORI, 24, 4, 'hffff), 3);
        send_inst(itype_word(O_SLTI, 25, 3, -8), 3);
        send_inst(itype_word(O_SLTIU, 26, 2, 'hffff), 3);
        send_inst(itype_word(O_LUI, 27, 0, 'hbeef), 3);
        finish_test("alu_ops");

        send_inst(itype_word(O_ADDIU, 5, 0, 3), 0);
        send_inst(rtype_word(F_ADDU, 5, 5, 5, 0), 0);
        send_inst(rtype_word(F_SLL, 6, 0, 5, 2), 0);
        send_inst(rtype_word(F_SUBU, 7, 6, 5, 0), 0);
        send_inst(rtype_word(F_XOR, 5, 7, 6, 0), 0);
        send_inst(rtype_word(F_NOR, 8, 5, 7, 0), 0);
        send_inst(rtype_word(F_SLT, 9, 8, 5, 0), 0);
        send_inst(itype_word(O_ADDIU, 9, 9, 100), 0);
        finish_test("chain");

        send_inst(itype_word(O_ADDIU, 5, 0, 11), 0);
        send_inst(itype_word(O_ORI, 6, 0, 'h22), 0);
        send_inst(rtype_word(F_ADDU, 7, 5, 0, 0), 0);
        send_inst(rtype_word(F_SUBU, 8, 6, 5, 0), 0);
        send_inst(rtype_word(F_XOR, 9, 7, 6, 0), 0);
        send_inst(itype_word(O_ADDIU, 10, 0, 55), 2);
        send_inst(rtype_word(F_ADDU, 11, 10, 10, 0), 5);
        send_inst(rtype_word(F_OR, 12, 11, 10, 0), 0);
        finish_test("distance");

        send_inst(itype_word(O_ADDIU, 0, 0, 99), 0);
        send_inst(rtype_word(F_ADDU, 13, 0, 0, 0), 0);
        send_inst(itype_word(O_ORI, 0, 0, 'hffff), 0);
        send_inst(rtype_word(F_OR, 14, 0, 0, 0), 0);
        // A load to $2 must not forward anything to the next word
        send_inst(32'h8c22_0000, 0);
        send_inst(rtype_word(F_ADDU, 15, 2, 0, 0), 0);
        send_inst(rtype_word('h18, 16, 1, 2, 0), 0);
        send_inst(32'hffff_ffff, 0);
        send_inst(itype_word(O_ADDIU, 16, 2, 1), 0);
        send_inst(32'h0000_0000, 0);
        finish_test("zero_unsup");

        for (int i = 0; i < RANDOM_N; i++) begin
            send_inst(random_word(), $urandom_range(0, 2));
        end
        finish_test("random");

        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
source/mips_pkg.sv
source/decode.sv
source/issue.sv
source/bypass.sv
source/regfile.sv
source/execute.sv
source/datapath.sv
verification/tb_clock.sv
verification/tb_datapath.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_datapath
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
